// ==== branch_redirect.f ====
rtl/branch_pkg.sv
rtl/branch_cmp.sv
rtl/btb_ctrl.sv
rtl/ctrl.sv
rtl/branch_redirect.sv
verif/redirect_checker.sv
verif/tb_branch_redirect.sv

// ==== rtl/branch_cmp.sv ====
////////////////////////////////////////////////////////////////////////////
// Branch condition and jump target of the execute stage, purely combinational.
// The target is always num1 + num2, even when the branch is not taken.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module branch_cmp import branch_pkg::*; (
	input  branch_req_t br_i,
	output redirect_t   res_o
);

	logic rs_eq;
	logic rs_lt;
	logic rs_ltu;
	logic taken;

	assign rs_eq  = (br_i.rs1 == br_i.rs2);
	assign rs_lt  = ($signed(br_i.rs1) < $signed(br_i.rs2));
	assign rs_ltu = (br_i.rs1 < br_i.rs2);

	always_comb begin
		case (br_i.flag)
			JMP_BEQ:  taken = rs_eq;
			JMP_BNE:  taken = !rs_eq;
			JMP_BLT:  taken = rs_lt;
			JMP_BGE:  taken = !rs_lt;
			JMP_BLTU: taken = rs_ltu;
			JMP_BGEU: taken = !rs_ltu;
			JMP_J:    taken = 1'b1;
			default:  taken = 1'b0; // JMP_NONE and unused codes
		endcase
	end

	assign res_o.en     = taken;
	assign res_o.target = br_i.num1 + br_i.num2;

endmodule

// ==== rtl/branch_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared widths, BTB geometry and bus types of the branch/redirect block.
// PRED_DEPTH must equal the fetch-to-execute distance of the pipeline.
// The tag width assumes word-aligned instruction addresses.
////////////////////////////////////////////////////////////////////////////

package branch_pkg;

	localparam int ADDR_W      = 32;
	localparam int DATA_W      = 32;
	localparam int BTB_IDX_W   = 4;
	localparam int BTB_ENTRIES = 1 << BTB_IDX_W;
	localparam int BTB_TAG_W   = ADDR_W - BTB_IDX_W - 2;
	localparam int PRED_DEPTH  = 2;

	typedef enum logic [3:0] {
		JMP_NONE = 4'd0,
		JMP_BEQ  = 4'd1,
		JMP_BNE  = 4'd2,
		JMP_BLT  = 4'd3,
		JMP_BGE  = 4'd4,
		JMP_BLTU = 4'd5,
		JMP_BGEU = 4'd6,
		JMP_J    = 4'd7
	} jmp_flag_e;

	typedef enum logic [1:0] {
		HOLD_NONE = 2'd0,
		HOLD_EX   = 2'd1 // freezes fetch, decode and execute
	} hold_code_e;

	typedef struct packed {
		jmp_flag_e         flag;
		logic [DATA_W-1:0] rs1;
		logic [DATA_W-1:0] rs2;
		logic [ADDR_W-1:0] num1; // target = num1 + num2
		logic [ADDR_W-1:0] num2;
		logic [ADDR_W-1:0] pc_instr;
	} branch_req_t;

	typedef struct packed {
		logic              en;
		logic [ADDR_W-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic              taken;
		logic [ADDR_W-1:0] target;
	} pred_t;

endpackage

// ==== rtl/branch_redirect.sv ====
////////////////////////////////////////////////////////////////////////////
// Top of the branch-resolution and redirect block.
// redirect_o, hold_code_o and fetch_pred_o are combinational from inputs.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module branch_redirect import branch_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              stall_if_i,
	input  logic              stall_mem_i,
	input  redirect_t         irq_i,
	input  logic [ADDR_W-1:0] pc_pred_i,
	input  branch_req_t       br_i,
	input  logic              load_bypass_i,
	output redirect_t         redirect_o,
	output pred_t             fetch_pred_o,
	output hold_code_e        hold_code_o,
	output logic              instr_mask_o
);

	ctrl u_ctrl (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.stall_if_i    (stall_if_i),
		.stall_mem_i   (stall_mem_i),
		.irq_i         (irq_i),
		.pc_pred_i     (pc_pred_i),
		.br_i          (br_i),
		.load_bypass_i (load_bypass_i),
		.redirect_o    (redirect_o),
		.fetch_pred_o  (fetch_pred_o),
		.hold_code_o   (hold_code_o),
		.instr_mask_o  (instr_mask_o)
	);

endmodule

// ==== rtl/btb_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Direct-mapped branch target buffer with PC[5:2] as index.
// Predictions travel PRED_DEPTH records to execute and are checked there.
// Table writes and record shifts only happen under HOLD_NONE.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module btb_ctrl import branch_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  hold_code_e        hold_code_i,
	input  logic [ADDR_W-1:0] pc_i,
	input  logic [ADDR_W-1:0] pc_jmp_i,
	input  redirect_t         res_i,
	output pred_t             fetch_pred_o,
	output pred_t             ex_pred_o,
	output logic              mispredict_o
);

	logic [BTB_ENTRIES-1:0] btb_valid;
	logic [BTB_TAG_W-1:0]   btb_tag [BTB_ENTRIES];
	logic [ADDR_W-1:0]      btb_target [BTB_ENTRIES];
	pred_t                  pred_q [PRED_DEPTH];

	logic [BTB_IDX_W-1:0]   rd_idx;
	logic [BTB_TAG_W-1:0]   rd_tag;
	logic [BTB_IDX_W-1:0]   wr_idx;
	logic [BTB_TAG_W-1:0]   wr_tag;
	logic                   rd_hit;
	logic                   advance;
	logic                   btb_wr;

	assign rd_idx = pc_i[BTB_IDX_W+1:2];
	assign rd_tag = pc_i[ADDR_W-1:BTB_IDX_W+2];
	assign wr_idx = pc_jmp_i[BTB_IDX_W+1:2];
	assign wr_tag = pc_jmp_i[ADDR_W-1:BTB_IDX_W+2];

	assign rd_hit = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);

	// a miss carries a zero target so untouched entries never leak out
	assign fetch_pred_o.taken  = rd_hit;
	assign fetch_pred_o.target = rd_hit ? btb_target[rd_idx] : '0;

	assign ex_pred_o = pred_q[PRED_DEPTH-1];

	assign mispredict_o = (ex_pred_o.taken != res_i.en) ||
		(res_i.en && (ex_pred_o.target != res_i.target));

	assign advance = (hold_code_i == HOLD_NONE);
	assign btb_wr  = advance && mispredict_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			btb_valid <= '0;
		end else if (btb_wr) begin
			btb_valid[wr_idx] <= res_i.en; // not taken drops the entry
		end
	end

	always_ff @(posedge clk) begin
		if (btb_wr && res_i.en) begin
			btb_tag[wr_idx]    <= wr_tag;
			btb_target[wr_idx] <= res_i.target;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < PRED_DEPTH; i++) begin
				pred_q[i] <= '0;
			end
		end else if (advance) begin
			pred_q[0] <= fetch_pred_o;
			for (int i = 1; i < PRED_DEPTH; i++) begin
				pred_q[i] <= pred_q[i-1];
			end
		end
	end

endmodule

// ==== rtl/ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Redirect selection, hold code and flush mask of the branch unit.
// Priority is interrupt, confirmed prediction, resolved branch, pc + 4.
// A load still in flight on an operand forces the branch to not taken.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ctrl import branch_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              stall_if_i,
	input  logic              stall_mem_i,
	input  redirect_t         irq_i,
	input  logic [ADDR_W-1:0] pc_pred_i,
	input  branch_req_t       br_i,
	input  logic              load_bypass_i,
	output redirect_t         redirect_o,
	output pred_t             fetch_pred_o,
	output hold_code_e        hold_code_o,
	output logic              instr_mask_o
);

	redirect_t res_cmp;
	redirect_t res;
	pred_t     ex_pred;
	logic      mispredict;
	logic      instr_mask_q;

	branch_cmp u_cmp (
		.br_i  (br_i),
		.res_o (res_cmp)
	);

	assign res.en     = res_cmp.en && !load_bypass_i;
	assign res.target = res_cmp.target;

	assign hold_code_o = (stall_mem_i || stall_if_i) ? HOLD_EX : HOLD_NONE;

	btb_ctrl u_btb (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.hold_code_i  (hold_code_o),
		.pc_i         (pc_pred_i),
		.pc_jmp_i     (br_i.pc_instr),
		.res_i        (res),
		.fetch_pred_o (fetch_pred_o),
		.ex_pred_o    (ex_pred),
		.mispredict_o (mispredict)
	);

	always_comb begin
		if (irq_i.en) begin
			redirect_o = irq_i;
		end else if (!mispredict) begin
			redirect_o.en     = ex_pred.taken; // fetch already went the right way
			redirect_o.target = ex_pred.target;
		end else if (res.en) begin
			redirect_o.en     = 1'b1;
			redirect_o.target = res.target;
		end else begin
			redirect_o.en     = 1'b1;
			redirect_o.target = br_i.pc_instr + ADDR_W'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			instr_mask_q <= 1'b0;
		end else if (hold_code_o == HOLD_NONE) begin
			instr_mask_q <= mispredict; // kills the wrongly fetched follower
		end
	end

	assign instr_mask_o = instr_mask_q;

endmodule

// ==== verif/branch_tests.txt ====
// test ctl irq_tgt pc_pred flag rs1 rs2 num1 num2 pc_instr exp_en exp_tgt hold mask fp fp_tgt
// ctl bits: 3 irq_i.en, 2 load_bypass_i, 1 stall_mem_i, 0 stall_if_i (all values hex)
// test 1: branch conditions with a cold BTB
1 0 0 0 1 1831a462 1831a462 1000 40 1000 1 1040 0 0 0 0
1 0 0 0 2 1831a462 1831a462 1004 8 1004 0 0 0 1 0 0
1 0 0 0 3 80000000 00000001 1008 fffffff8 1008 1 1000 0 0 0 0
1 0 0 0 5 80000000 00000001 100c 10 100c 0 0 0 1 0 0
1 0 0 0 4 7fffffff 80000000 1010 10 1010 1 1020 0 0 0 0
1 0 0 0 6 7fffffff 80000000 1014 10 1014 0 0 0 1 0 0
1 0 0 0 5 1831a462 e7ce5b9d 1018 100 1018 1 1118 0 0 0 0
1 0 0 0 3 1831a462 e7ce5b9d 101c 100 101c 0 0 0 1 0 0
1 0 0 0 7 0 0 1020 200 1020 1 1220 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0
// test 2: mispredictions, then a stored taken entry resolved not taken
2 0 0 0 1 5 6 2004 10 2004 0 0 0 0 0 0
2 0 0 0 2 5 6 200c 30 200c 1 203c 0 0 0 0
2 0 0 200c 0 0 0 0 0 0 0 0 0 1 1 203c
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 1 5 6 200c 30 200c 1 2010 0 0 0 0
2 0 0 200c 0 0 0 0 0 0 0 0 0 1 0 0
// test 3: a learned branch predicts and resolves the same way
3 0 0 0 4 10 10 3014 80 3014 1 3094 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0
3 0 0 3014 0 0 0 0 0 0 0 0 0 0 1 3094
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 4 10 10 3014 80 3014 1 3094 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
// test 4: interrupt wins over the branch state
4 8 80 0 7 0 0 4000 100 4000 1 80 0 0 0 0
4 8 80 0 0 0 0 0 0 0 1 80 0 1 0 0
// test 5: fetch and memory stalls freeze mask, records and table
5 0 0 3014 0 0 0 0 0 0 0 0 0 0 1 3094
5 1 0 5020 7 0 0 5020 40 5020 1 5060 1 0 0 0
5 2 0 5020 7 0 0 5020 40 5020 1 5060 1 0 0 0
5 0 0 5020 7 0 0 5020 40 5020 1 5060 0 0 0 0
5 0 0 5020 4 10 10 3014 80 3014 1 3094 0 1 1 5060
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
// test 6: load bypass forces not taken
6 4 0 0 7 0 0 5020 40 5020 1 5024 0 0 0 0
6 4 0 0 5 1 2 6004 10 6004 0 0 0 1 0 0
6 0 0 5020 0 0 0 0 0 0 0 0 0 0 0 0
6 0 0 0 5 1 2 6004 10 6004 1 6014 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0

// ==== verif/redirect_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Compares the DUT outputs with the expected values of one stimulus line.
// Samples on the falling edge, half a cycle after the inputs changed.
// last_i closes a test and final_i closes the whole run.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module redirect_checker import branch_pkg::*; (
	input  logic       clk,
	input  logic       valid_i,
	input  logic       last_i,
	input  logic       final_i,
	input  int         test_i,
	input  redirect_t  redirect_i,
	input  pred_t      fetch_pred_i,
	input  hold_code_e hold_code_i,
	input  logic       instr_mask_i,
	input  redirect_t  exp_redirect_i,
	input  pred_t      exp_pred_i,
	input  hold_code_e exp_hold_i,
	input  logic       exp_mask_i,
	output int         bad_tests_o
);

	int errors_in_test = 0;
	int good_tests     = 0;
	int bad_tests      = 0;

	assign bad_tests_o = bad_tests;

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0d ns: test %0d %s is %h, expected %h",
				$time, test_i, what, got, exp);
			errors_in_test++;
		end
	endtask

	always @(negedge clk) begin
		if (valid_i) begin
			compare("redirect_o.en", 32'(redirect_i.en), 32'(exp_redirect_i.en));
			compare("redirect_o.target", redirect_i.target, exp_redirect_i.target);
			compare("hold_code_o", 32'(hold_code_i), 32'(exp_hold_i));
			compare("instr_mask_o", 32'(instr_mask_i), 32'(exp_mask_i));
			compare("fetch_pred_o.taken", 32'(fetch_pred_i.taken), 32'(exp_pred_i.taken));
			compare("fetch_pred_o.target", fetch_pred_i.target, exp_pred_i.target);
			if (last_i) begin
				if (errors_in_test == 0) begin
					$display("test %0d ok", test_i);
					good_tests++;
				end else begin
					$display("test %0d had %0d mismatches", test_i, errors_in_test);
					bad_tests++;
				end
				errors_in_test = 0;
			end
			if (final_i) begin
				$display("%0d tests ok, %0d tests with mismatches", good_tests, bad_tests);
			end
		end
	end

endmodule

// ==== verif/tb_branch_redirect.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench of branch_redirect, stepping one line of verif/branch_tests.txt
// per clock. Each line holds 16 hex words and lines of one test are adjacent.
// Run from the project root so that the relative stimulus path resolves.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_branch_redirect import branch_pkg::*; ();

	localparam int FIELDS    = 16;
	localparam int MAX_LINES = 128;
	localparam int CLK_NS    = 100;

	logic              clk;
	logic              rst_n_i;
	logic              stall_if_i;
	logic              stall_mem_i;
	redirect_t         irq_i;
	logic [ADDR_W-1:0] pc_pred_i;
	branch_req_t       br_i;
	logic              load_bypass_i;
	redirect_t         redirect_o;
	pred_t             fetch_pred_o;
	hold_code_e        hold_code_o;
	logic              instr_mask_o;

	logic [31:0] tests [FIELDS*MAX_LINES];
	int          n_lines = 0;
	logic        chk_valid;
	logic        chk_last;
	logic        chk_final;
	int          chk_test;
	redirect_t   exp_redirect;
	pred_t       exp_pred;
	hold_code_e  exp_hold;
	logic        exp_mask;
	int          bad_tests;

	initial clk = 1'b0;
	always #(CLK_NS/2) clk = !clk;

	branch_redirect DUT (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.stall_if_i    (stall_if_i),
		.stall_mem_i   (stall_mem_i),
		.irq_i         (irq_i),
		.pc_pred_i     (pc_pred_i),
		.br_i          (br_i),
		.load_bypass_i (load_bypass_i),
		.redirect_o    (redirect_o),
		.fetch_pred_o  (fetch_pred_o),
		.hold_code_o   (hold_code_o),
		.instr_mask_o  (instr_mask_o)
	);

	redirect_checker u_checker (
		.clk            (clk),
		.valid_i        (chk_valid),
		.last_i         (chk_last),
		.final_i        (chk_final),
		.test_i         (chk_test),
		.redirect_i     (redirect_o),
		.fetch_pred_i   (fetch_pred_o),
		.hold_code_i    (hold_code_o),
		.instr_mask_i   (instr_mask_o),
		.exp_redirect_i (exp_redirect),
		.exp_pred_i     (exp_pred),
		.exp_hold_i     (exp_hold),
		.exp_mask_i     (exp_mask),
		.bad_tests_o    (bad_tests)
	);

	task automatic apply_line(input int ln);
		int         base;
		logic [3:0] ctl;
		base = ln * FIELDS;
		ctl  = tests[base+1][3:0]; // irq, bypass, stall_mem, stall_if from msb down
		stall_if_i          <= ctl[0];
		stall_mem_i         <= ctl[1];
		load_bypass_i       <= ctl[2];
		irq_i.en            <= ctl[3];
		irq_i.target        <= tests[base+2];
		pc_pred_i           <= tests[base+3];
		br_i.flag           <= jmp_flag_e'(tests[base+4][3:0]);
		br_i.rs1            <= tests[base+5];
		br_i.rs2            <= tests[base+6];
		br_i.num1           <= tests[base+7];
		br_i.num2           <= tests[base+8];
		br_i.pc_instr       <= tests[base+9];
		exp_redirect.en     <= tests[base+10][0];
		exp_redirect.target <= tests[base+11];
		exp_hold            <= hold_code_e'(tests[base+12][1:0]);
		exp_mask            <= tests[base+13][0];
		exp_pred.taken      <= tests[base+14][0];
		exp_pred.target     <= tests[base+15];
		chk_test            <= tests[base];
		chk_last            <= (ln == n_lines-1) || (tests[base+FIELDS] !== tests[base]);
		chk_final           <= (ln == n_lines-1);
		chk_valid           <= 1'b1;
	endtask

	initial begin
		rst_n_i       = 1'b0;
		stall_if_i    = 1'b0;
		stall_mem_i   = 1'b0;
		irq_i         = '0;
		pc_pred_i     = '0;
		br_i          = '0;
		load_bypass_i = 1'b0;
		chk_valid     = 1'b0;
		chk_last      = 1'b0;
		chk_final     = 1'b0;
		chk_test      = 0;
		exp_redirect  = '0;
		exp_pred      = '0;
		exp_hold      = HOLD_NONE;
		exp_mask      = 1'b0;
		$readmemh("verif/branch_tests.txt", tests);
		while (n_lines < MAX_LINES && !$isunknown(tests[n_lines*FIELDS])) begin
			n_lines++;
		end
		if (n_lines == 0) begin
			$display("no stimulus lines could be read from verif/branch_tests.txt");
		end else begin
			repeat (5) @(posedge clk);
			rst_n_i <= 1'b1; // the fifth edge still sees reset low
			for (int ln = 0; ln < n_lines; ln++) begin
				apply_line(ln);
				@(posedge clk);
			end
			chk_valid <= 1'b0;
			@(posedge clk);
		end
		if (n_lines > 0 && bad_tests == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		wait (n_lines > 0);
		#((n_lines + 5 + 20) * CLK_NS);
		$display("timeout: the run did not end within the time of %0d stimulus lines", n_lines);
		$display("test failed");
		$finish;
	end

endmodule
